// File: sources.f
logic/dcache_pkg.sv
logic/dual_port_ram.sv
logic/dcache_bank.sv
logic/bank_router.sv
logic/mem_arbiter.sv
logic/dcache_top.sv
testbench/dcache_checker.sv
testbench/dcache_tb.sv

// File: Makefile
# Verilator build and run for the banked data cache
VERILATOR ?= verilator
TOP ?= dcache_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
FAIL_MSG ?= TEST FAILED
PASS_MSG ?= TEST PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory and log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation stopped early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/dcache_tb.sv
// Testbench for the banked data cache
// Clock, reset, memory model, stimulus table and reference checks
module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 200;
    localparam int mem_words = 2 ** dcache_pkg::addr_bits;
    // Lines pushed out by dirty evictions
    localparam logic [15:0] flushed_lines [3] = '{16'h0100, 16'h0104, 16'h0304};

    // Hit marks an access that must ack after two cycles
    typedef struct packed {
        logic [15:0] addr;
        logic        write;
        logic [15:0] data;
        logic [1:0]  bytesel;
        logic        hit;
    } entry_t;

    logic        clk;
    logic        reset;
    logic [15:0] addr;
    logic [15:0] wdata;
    logic        access;
    logic        wr_en;
    logic [1:0]  bytesel;
    logic [15:0] rdata;
    logic        ack;
    logic [15:0] m_rdata;
    logic        m_ack;
    logic [15:0] m_addr;
    logic [15:0] m_wdata;
    logic        m_access;
    logic        m_wr_en;
    logic [1:0]  m_bytesel;

    // Memory model and the expected memory image
    logic [15:0] mem [mem_words];
    logic [15:0] ref_mem [mem_words];
    entry_t      table_q [$];
    int          seed;
    int          pending;

    dcache_top dut (
        .clk(clk), .reset(reset), .addr(addr), .wdata(wdata), .access(access),
        .wr_en(wr_en), .bytesel(bytesel), .rdata(rdata), .ack(ack),
        .m_rdata(m_rdata), .m_ack(m_ack), .m_addr(m_addr), .m_wdata(m_wdata),
        .m_access(m_access), .m_wr_en(m_wr_en), .m_bytesel(m_bytesel)
    );

    bind dcache_bank dcache_checker u_checker (
        .clk(clk), .reset(reset), .ack(ack), .m_access(m_access),
        .m_ack(m_ack), .m_wr_en(m_wr_en), .state(state)
    );

    always #4 clk = ~clk;

    // Initial memory word, every address bit feeds in
    function automatic logic [15:0] pattern_word(input logic [15:0] a);
        return {a[7:0] ^ a[15:8], a[15:8]} ^ 16'hc35a;
    endfunction

    // Selected byte lanes come from the new word
    function automatic logic [15:0] merge_lanes(input logic [15:0] old_word,
                                                input logic [15:0] new_word,
                                                input logic [1:0] sel);
        logic [15:0] merged;
        merged = old_word;
        for (int l = 0; l < 2; l++) begin
            if (sel[l])
                merged[l*8 +: 8] = new_word[l*8 +: 8];
        end
        return merged;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail %0t ns: %s got %h expected %h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Word transfers answered after 1 to 3 cycles
    always @(posedge clk) begin
        #1;
        m_ack = 1'b0;
        m_rdata = '0;
        if (m_access === 1'b1) begin
            // Line transfers move whole words
            check_value("m_bytesel", 32'(m_bytesel), 32'h3);
            if (pending == 0)
                pending = 1 + int'($unsigned($random(seed)) % 3);
            pending = pending - 1;
            if (pending == 0) begin
                if (m_wr_en)
                    mem[m_addr] = merge_lanes(mem[m_addr], m_wdata, m_bytesel);
                else
                    m_rdata = mem[m_addr];
                m_ack = 1'b1;
            end
        end
    end

    task automatic add_entry(input logic [15:0] a, input logic w, input logic [15:0] d,
                             input logic [1:0] bs, input logic hit);
        table_q.push_back({a, w, d, bs, hit});
    endtask

    // One processor access, held until ack
    task automatic apply_entry(input entry_t e);
        int cycles;
        @(posedge clk);
        #1;
        addr = e.addr;
        wdata = e.data;
        wr_en = e.write;
        bytesel = e.bytesel;
        access = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("No ack for address %h within %0d cycles", e.addr, timeout_cycles);
                $display("TEST FAILED");
                $fatal(1, "access timeout");
            end
        end while (ack !== 1'b1);
        if (e.write) begin
            check_value("write rdata", 32'(rdata), 32'h0);
            ref_mem[e.addr] = merge_lanes(ref_mem[e.addr], e.data, e.bytesel);
        end else begin
            check_value("read data", 32'(rdata), 32'(ref_mem[e.addr]));
        end
        if (e.hit)
            check_value("hit latency", 32'(cycles), 32'd2);
        else
            check_value("miss slower than hit", 32'(cycles > 2), 32'd1);
        @(posedge clk);
        #1;
        access = 1'b0;
        wr_en = 1'b0;
    endtask

    task automatic build_table();
        // Miss then hits in bank 0, set 0
        add_entry(16'h0100, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry(16'h0101, 1'b0, 16'h0000, 2'b11, 1'b1);
        add_entry(16'h0103, 1'b0, 16'h0000, 2'b11, 1'b1);
        // Byte lane merges
        add_entry(16'h0101, 1'b1, 16'hab12, 2'b01, 1'b1);
        add_entry(16'h0102, 1'b1, 16'h34cd, 2'b10, 1'b1);
        add_entry(16'h0103, 1'b1, 16'hbeef, 2'b11, 1'b1);
        add_entry(16'h0101, 1'b0, 16'h0000, 2'b11, 1'b1);
        add_entry(16'h0102, 1'b0, 16'h0000, 2'b11, 1'b1);
        add_entry(16'h0103, 1'b0, 16'h0000, 2'b11, 1'b1);
        add_entry(16'h0101, 1'b1, 16'h7700, 2'b10, 1'b1);
        add_entry(16'h0101, 1'b0, 16'h0000, 2'b11, 1'b1);
        // Same set, new tag evicts the dirty line
        add_entry(16'h0200, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry(16'h0203, 1'b0, 16'h0000, 2'b11, 1'b1);
        add_entry(16'h0101, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry(16'h0102, 1'b0, 16'h0000, 2'b11, 1'b1);
        add_entry(16'h0103, 1'b0, 16'h0000, 2'b11, 1'b1);
        // Both banks in turn
        add_entry(16'h0105, 1'b1, 16'h1111, 2'b11, 1'b0);
        add_entry(16'h0009, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry(16'h0305, 1'b1, 16'h2222, 2'b11, 1'b0);
        add_entry(16'h0105, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry(16'h000a, 1'b0, 16'h0000, 2'b11, 1'b1);
        add_entry(16'h0305, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry(16'h00fc, 1'b1, 16'h5a5a, 2'b10, 1'b0);
        add_entry(16'h00fc, 1'b0, 16'h0000, 2'b11, 1'b1);
        add_entry(16'h00ff, 1'b0, 16'h0000, 2'b11, 1'b1);
    endtask

    initial begin
        logic [15:0] word_addr;
        clk = 1'b0;
        reset = 1'b1;
        addr = '0;
        wdata = '0;
        access = 1'b0;
        wr_en = 1'b0;
        bytesel = '0;
        m_rdata = '0;
        m_ack = 1'b0;
        seed = 32'h6415;
        pending = 0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = pattern_word(16'(i));
            ref_mem[i] = mem[i];
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        // Quiet ports while nothing is asked
        repeat (10) begin
            @(posedge clk);
            #1;
            check_value("idle ack", 32'(ack), 32'h0);
            check_value("idle rdata", 32'(rdata), 32'h0);
            check_value("idle m_access", 32'(m_access), 32'h0);
            check_value("idle m_wr_en", 32'(m_wr_en), 32'h0);
        end
        build_table();
        foreach (table_q[i])
            apply_entry(table_q[i]);
        // Evicted lines reached memory
        for (int j = 0; j < 3; j++) begin
            for (int k = 0; k < 4; k++) begin
                word_addr = flushed_lines[j] + 16'(k);
                check_value("memory word", 32'(mem[word_addr]), 32'(ref_mem[word_addr]));
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: testbench/dcache_checker.sv
// Bound protocol assertions for one cache bank
// Processor ack pulse, memory request hold and writeback direction
module dcache_checker (
    input logic                    clk,
    input logic                    reset,
    input logic                    ack,
    input logic                    m_access,
    input logic                    m_ack,
    input logic                    m_wr_en,
    input dcache_pkg::bank_state_t state
);
    timeunit 1ns;
    timeprecision 100ps;

    // Processor ack is a single cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack held longer than one cycle");

    // Word request stays up until memory answers
    request_held: assert property (@(posedge clk) disable iff (reset)
        m_access && !m_ack |=> m_access)
        else $error("m_access dropped before m_ack");

    // A victim word stays a write in flush until memory answers
    flush_writes: assert property (@(posedge clk) disable iff (reset)
        (state == dcache_pkg::flush && m_access && m_wr_en && !m_ack) |=>
        (state == dcache_pkg::flush && m_wr_en))
        else $error("writeback word changed before m_ack");

endmodule

// File: logic/dcache_top.sv
// Banked data cache top level
// Router, one cache bank per bank index and the memory arbiter
module dcache_top (
    input  logic                               clk,
    input  logic                               reset,
    // Processor data port
    input  logic [dcache_pkg::addr_bits-1:0]   addr,
    input  logic [dcache_pkg::data_bits-1:0]   wdata,
    input  logic                               access,
    input  logic                               wr_en,
    input  logic [dcache_pkg::byte_lanes-1:0]  bytesel,
    output logic [dcache_pkg::data_bits-1:0]   rdata,
    output logic                               ack,
    // Memory port
    input  logic [dcache_pkg::data_bits-1:0]   m_rdata,
    input  logic                               m_ack,
    output logic [dcache_pkg::addr_bits-1:0]   m_addr,
    output logic [dcache_pkg::data_bits-1:0]   m_wdata,
    output logic                               m_access,
    output logic                               m_wr_en,
    output logic [dcache_pkg::byte_lanes-1:0]  m_bytesel
);

    // Router to banks
    logic [dcache_pkg::num_banks-1:0]                            bank_access;
    logic [dcache_pkg::num_banks-1:0]                            bank_ack;
    logic [dcache_pkg::num_banks-1:0][dcache_pkg::data_bits-1:0] bank_rdata;

    // Banks to arbiter
    logic [dcache_pkg::num_banks-1:0]                            bank_m_access;
    logic [dcache_pkg::num_banks-1:0][dcache_pkg::addr_bits-1:0] bank_m_addr;
    logic [dcache_pkg::num_banks-1:0][dcache_pkg::data_bits-1:0] bank_m_wdata;
    logic [dcache_pkg::num_banks-1:0]                            bank_m_wr_en;
    logic [dcache_pkg::num_banks-1:0]                            bank_m_ack;
    logic [dcache_pkg::num_banks-1:0][dcache_pkg::data_bits-1:0] bank_m_rdata;

    bank_router u_router (
        .addr(addr), .access(access), .bank_access(bank_access),
        .bank_ack(bank_ack), .bank_rdata(bank_rdata), .rdata(rdata), .ack(ack)
    );

    // Address, data, write and lane select shared by all banks
    for (genvar i = 0; i < dcache_pkg::num_banks; i++) begin : g_bank
        dcache_bank u_bank (
            .clk(clk), .reset(reset),
            .addr(addr), .wdata(wdata), .wr_en(wr_en), .bytesel(bytesel),
            .access(bank_access[i]), .rdata(bank_rdata[i]), .ack(bank_ack[i]),
            .m_addr(bank_m_addr[i]), .m_wdata(bank_m_wdata[i]),
            .m_access(bank_m_access[i]), .m_wr_en(bank_m_wr_en[i]),
            .m_rdata(bank_m_rdata[i]), .m_ack(bank_m_ack[i])
        );
    end

    mem_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .bank_m_access(bank_m_access), .bank_m_addr(bank_m_addr),
        .bank_m_wdata(bank_m_wdata), .bank_m_wr_en(bank_m_wr_en),
        .bank_m_ack(bank_m_ack), .bank_m_rdata(bank_m_rdata),
        .m_rdata(m_rdata), .m_ack(m_ack), .m_addr(m_addr), .m_wdata(m_wdata),
        .m_access(m_access), .m_wr_en(m_wr_en), .m_bytesel(m_bytesel)
    );

endmodule

// File: logic/mem_arbiter.sv
// Round-robin arbiter for bank line transfers
// One granted bank drives the word-wide memory port
module mem_arbiter (
    input  logic                                                     clk,
    input  logic                                                     reset,
    input  logic [dcache_pkg::num_banks-1:0]                         bank_m_access,
    input  logic [dcache_pkg::num_banks-1:0][dcache_pkg::addr_bits-1:0] bank_m_addr,
    input  logic [dcache_pkg::num_banks-1:0][dcache_pkg::data_bits-1:0] bank_m_wdata,
    input  logic [dcache_pkg::num_banks-1:0]                         bank_m_wr_en,
    output logic [dcache_pkg::num_banks-1:0]                         bank_m_ack,
    output logic [dcache_pkg::num_banks-1:0][dcache_pkg::data_bits-1:0] bank_m_rdata,
    input  logic [dcache_pkg::data_bits-1:0]                         m_rdata,
    input  logic                                                     m_ack,
    output logic [dcache_pkg::addr_bits-1:0]                         m_addr,
    output logic [dcache_pkg::data_bits-1:0]                         m_wdata,
    output logic                                                     m_access,
    output logic                                                     m_wr_en,
    output logic [dcache_pkg::byte_lanes-1:0]                        m_bytesel
);

    logic [dcache_pkg::bank_bits-1:0] grant;
    logic [dcache_pkg::bank_bits-1:0] sel;
    logic [dcache_pkg::bank_bits-1:0] cand;
    logic [dcache_pkg::bank_bits-1:0] step;
    logic [dcache_pkg::num_banks-1:0] grant_hot;
    logic locked;
    logic sel_valid;

    // Keep the locked bank while it requests
    // otherwise search from the bank after the last grant
    always_comb begin
        sel = grant;
        sel_valid = 1'b0;
        cand = grant;
        step = '0;
        if (locked && bank_m_access[grant]) begin
            sel_valid = 1'b1;
        end else begin
            for (int i = 1; i <= dcache_pkg::num_banks; i++) begin
                // Truncation wraps the search around
                step = i[dcache_pkg::bank_bits-1:0];
                cand = grant + step;
                if (!sel_valid && bank_m_access[cand]) begin
                    sel = cand;
                    sel_valid = 1'b1;
                end
            end
        end
    end

    // Grant lock lasts until the request drops
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant <= '0;
            locked <= 1'b0;
        end else begin
            grant <= sel;
            locked <= sel_valid;
        end
    end

    assign grant_hot = sel_valid ? ({{(dcache_pkg::num_banks-1){1'b0}}, 1'b1} << sel) : '0;

    // Granted bank to memory
    assign m_access = sel_valid;
    assign m_addr = bank_m_addr[sel];
    assign m_wdata = bank_m_wdata[sel];
    assign m_wr_en = sel_valid && bank_m_wr_en[sel];
    // Line transfers always move whole words
    assign m_bytesel = '1;

    // Memory response back to the granted bank only
    always_comb begin
        for (int i = 0; i < dcache_pkg::num_banks; i++) begin
            bank_m_ack[i] = m_ack && grant_hot[i];
            bank_m_rdata[i] = grant_hot[i] ? m_rdata : '0;
        end
    end

endmodule

// File: logic/bank_router.sv
// Processor access steering to one cache bank
// Read data and ack return from the addressed bank
module bank_router (
    input  logic [dcache_pkg::addr_bits-1:0]                         addr,
    input  logic                                                     access,
    output logic [dcache_pkg::num_banks-1:0]                         bank_access,
    input  logic [dcache_pkg::num_banks-1:0]                         bank_ack,
    input  logic [dcache_pkg::num_banks-1:0][dcache_pkg::data_bits-1:0] bank_rdata,
    output logic [dcache_pkg::data_bits-1:0]                         rdata,
    output logic                                                     ack
);

    logic [dcache_pkg::bank_bits-1:0] bank_sel;
    logic [dcache_pkg::num_banks-1:0] bank_hot;

    // Lowest index bits pick the bank
    assign bank_sel = addr[dcache_pkg::bank_lo +: dcache_pkg::bank_bits];

    // One-hot decode of the bank number
    assign bank_hot = {{(dcache_pkg::num_banks-1){1'b0}}, 1'b1} << bank_sel;

    // Only the addressed bank sees the strobe
    assign bank_access = access ? bank_hot : '0;

    // Return path from that same bank
    // Addr is held until ack so the select is stable
    assign rdata = bank_rdata[bank_sel];
    assign ack = bank_ack[bank_sel];

endmodule

// File: logic/dcache_bank.sv
// One direct-mapped write-back cache bank
// Tag, valid, dirty and line RAMs with flush and fill sequencing
module dcache_bank (
    input  logic                               clk,
    input  logic                               reset,
    // Processor side, held until ack
    input  logic [dcache_pkg::addr_bits-1:0]   addr,
    input  logic [dcache_pkg::data_bits-1:0]   wdata,
    input  logic                               wr_en,
    input  logic [dcache_pkg::byte_lanes-1:0]  bytesel,
    input  logic                               access,
    output logic [dcache_pkg::data_bits-1:0]   rdata,
    output logic                               ack,
    // Backend word transfers
    output logic [dcache_pkg::addr_bits-1:0]   m_addr,
    output logic [dcache_pkg::data_bits-1:0]   m_wdata,
    output logic                               m_access,
    output logic                               m_wr_en,
    input  logic [dcache_pkg::data_bits-1:0]   m_rdata,
    input  logic                               m_ack
);

    dcache_pkg::bank_state_t state, next_state;

    logic [dcache_pkg::set_bits-1:0]    set_idx;
    logic [dcache_pkg::set_bits-1:0]    sweep_idx;
    logic [dcache_pkg::tag_bits-1:0]    req_tag;
    logic [dcache_pkg::tag_bits-1:0]    tag_q;
    logic [dcache_pkg::tag_bits-1:0]    victim_tag;
    logic [dcache_pkg::offset_bits-1:0] word_idx;
    logic [dcache_pkg::offset_bits-1:0] word_sel;
    logic [dcache_pkg::data_bits-1:0]   line_q;
    logic [dcache_pkg::data_bits-1:0]   flush_q;
    logic valid_q;
    logic dirty_q;
    logic hit;
    logic victim_dirty;
    logic write_hit;
    logic start_fill;
    logic sweeping;
    logic last_word;

    // Address fields of the current request
    assign set_idx = addr[dcache_pkg::set_lo +: dcache_pkg::set_bits];
    assign req_tag = addr[dcache_pkg::tag_lo +: dcache_pkg::tag_bits];

    // Lookup result from RAM outputs
    assign hit = valid_q && (tag_q == req_tag);
    assign victim_dirty = valid_q && dirty_q;
    assign write_hit = (state == dcache_pkg::lookup) && hit && wr_en;
    assign last_word = (word_idx == dcache_pkg::offset_bits'(dcache_pkg::line_words - 1));

    // New tag, valid and clean are written when the fill begins
    // so that the lookup after the fill reads them back settled
    assign start_fill = ((state == dcache_pkg::lookup) && !hit && !victim_dirty) ||
                        ((state == dcache_pkg::flush) && m_ack && last_word);

    // Flush reads one word ahead so the next word is ready after each ack
    assign word_sel = ((state == dcache_pkg::flush) && m_ack) ? word_idx + 1'b1 : word_idx;

    dual_port_ram #(.words(dcache_pkg::bank_lines), .width(dcache_pkg::tag_bits)) tag_ram (
        .clk(clk),
        .addr_a(set_idx), .wr_en_a(1'b0), .wdata_a('0), .be_a('0), .q_a(tag_q),
        .addr_b(set_idx), .wr_en_b(start_fill), .wdata_b(req_tag), .q_b()
    );

    // Port b shared by the reset sweep and fill
    dual_port_ram #(.words(dcache_pkg::bank_lines), .width(1)) valid_ram (
        .clk(clk),
        .addr_a(set_idx), .wr_en_a(1'b0), .wdata_a(1'b0), .be_a(1'b0), .q_a(valid_q),
        .addr_b(sweeping ? sweep_idx : set_idx), .wr_en_b(sweeping || start_fill),
        .wdata_b(!sweeping), .q_b()
    );

    // Set by write hits, cleared by fill
    dual_port_ram #(.words(dcache_pkg::bank_lines), .width(1)) dirty_ram (
        .clk(clk),
        .addr_a(set_idx), .wr_en_a(write_hit), .wdata_a(1'b1), .be_a(1'b1), .q_a(dirty_q),
        .addr_b(set_idx), .wr_en_b(start_fill), .wdata_b(1'b0), .q_b()
    );

    // Port a for processor hits, port b for line transfers
    dual_port_ram #(.words(dcache_pkg::bank_words), .width(dcache_pkg::data_bits)) line_ram (
        .clk(clk),
        .addr_a({set_idx, addr[dcache_pkg::offset_bits-1:0]}), .wr_en_a(write_hit),
        .wdata_a(wdata), .be_a(bytesel), .q_a(line_q),
        .addr_b({set_idx, word_sel}), .wr_en_b((state == dcache_pkg::fill) && m_ack),
        .wdata_b(m_rdata), .q_b(flush_q)
    );

    // Clear every valid bit after reset, one set per cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sweeping <= 1'b1;
            sweep_idx <= '0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx)
                sweeping <= 1'b0;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // Hold off new accesses during the sweep
            dcache_pkg::idle:
                if (access && !sweeping)
                    next_state = dcache_pkg::lookup;
            dcache_pkg::lookup:
                if (hit)
                    next_state = dcache_pkg::respond;
                else if (victim_dirty)
                    next_state = dcache_pkg::flush;
                else
                    next_state = dcache_pkg::fill;
            dcache_pkg::flush:
                if (m_ack && last_word)
                    next_state = dcache_pkg::fill;
            // Back to lookup which now hits
            dcache_pkg::fill:
                if (m_ack && last_word)
                    next_state = dcache_pkg::lookup;
            dcache_pkg::respond:
                next_state = dcache_pkg::idle;
            default:
                next_state = dcache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= dcache_pkg::idle;
            word_idx <= '0;
        end else begin
            state <= next_state;
            // Wraps to zero at the end of each burst
            if (m_ack && m_access)
                word_idx <= word_idx + 1'b1;
        end
    end

    // Old tag kept for the writeback address
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::lookup)
            victim_tag <= tag_q;
    end

    // Request held across flush and fill as one burst
    assign m_access = (state == dcache_pkg::flush) || (state == dcache_pkg::fill);
    assign m_wr_en = (state == dcache_pkg::flush);
    assign m_wdata = flush_q;
    assign m_addr = {(state == dcache_pkg::flush) ? victim_tag : req_tag,
                     addr[dcache_pkg::tag_lo-1:dcache_pkg::offset_bits], word_idx};

    assign ack = (state == dcache_pkg::respond);
    // Zero except for a read ack
    assign rdata = (ack && !wr_en) ? line_q : '0;

endmodule

// File: logic/dual_port_ram.sv
// Two-port synchronous RAM, byte enables on port a
module dual_port_ram #(
    parameter int words = 128,
    parameter int width = 16
) (
    input  logic                       clk,
    // Port a with per-byte write enable
    input  logic [$clog2(words)-1:0]   addr_a,
    input  logic                       wr_en_a,
    input  logic [width-1:0]           wdata_a,
    input  logic [(width+7)/8-1:0]     be_a,
    output logic [width-1:0]           q_a,
    // Port b writes the whole word
    input  logic [$clog2(words)-1:0]   addr_b,
    input  logic                       wr_en_b,
    input  logic [width-1:0]           wdata_b,
    output logic [width-1:0]           q_b
);

    logic [width-1:0] mem [words];

    // Writes from both ports, port b last
    always_ff @(posedge clk) begin
        if (wr_en_a) begin
            for (int i = 0; i < width; i++) begin
                // Each bit follows the enable of its byte
                if (be_a[i / 8])
                    mem[addr_a][i] <= wdata_a[i];
            end
        end
        if (wr_en_b)
            mem[addr_b] <= wdata_b;
    end

    // One cycle read latency on both ports
    // Read during write returns the old word
    always_ff @(posedge clk) begin
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
    end

endmodule

// File: logic/dcache_pkg.sv
// Shared cache geometry, address split and bank state encoding
package dcache_pkg;

    // Word address and data widths
    localparam int addr_bits = 16;
    localparam int data_bits = 16;
    localparam int byte_lanes = data_bits / 8;

    // Words per line
    localparam int offset_bits = 2;
    localparam int line_words = 2 ** offset_bits;

    // Bank select taken from the lowest index bits
    localparam int bank_bits = 1;
    localparam int num_banks = 2 ** bank_bits;

    // Lines held by each bank
    localparam int set_bits = 5;
    localparam int bank_lines = 2 ** set_bits;
    localparam int bank_words = bank_lines * line_words;

    // Remaining upper bits form the tag
    localparam int tag_bits = addr_bits - offset_bits - bank_bits - set_bits;

    // Field positions inside a word address
    // Layout is tag | set | bank | offset
    localparam int bank_lo = offset_bits;
    localparam int set_lo = offset_bits + bank_bits;
    localparam int tag_lo = set_lo + set_bits;

    // Bank sequencing
    typedef enum logic [2:0] {
        idle,
        lookup,
        flush,
        fill,
        respond
    } bank_state_t;

endpackage
